/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core_top \
  -f rv_core_top.f -o sim_rv_core

./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  exit 1
fi

/* rv_core_top.f */
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_top.sv
sim/rv_core_assertions.sv
sim/tb_rv_core_top.sv

/* sim/rv_core_assertions.sv */
`default_nettype none

module rv_core_assertions import rv_pkg::*; (
  input logic        clk,
  input logic        reset,
  input logic [31:0] pc,
  input logic        halt,
  input wb_req_t     wb_req,
  input logic        wb_ack,
  input logic        stall
);
  timeunit 1ns;
  timeprecision 100ps;

  // classic bus, stb only inside a cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb |-> wb_req.cyc)
    else $error("stb high without cyc");

  // request frozen until ack
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb && !wb_ack |=> $stable(wb_req))
    else $error("request changed before ack");

  a_no_cyc_halted: assert property (@(posedge clk) disable iff (reset)
    halt |-> !wb_req.cyc)
    else $error("bus cycle while halted");

  // bus stays idle while reset is applied
  a_reset_bus: assert property (@(posedge clk)
    reset |-> !wb_req.cyc && !wb_req.stb && !wb_req.we)
    else $error("bus active during reset");

  // reset clears halt
  a_reset_state: assert property (@(posedge clk)
    reset |=> !halt)
    else $error("halt set after reset");

  // stalled instruction keeps its pc
  a_pc_hold: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(pc))
    else $error("pc moved during stall");

endmodule

bind rv_core_top rv_core_assertions i_assertions (
  .clk    (clk),
  .reset  (reset),
  .pc     (pc),
  .halt   (halt),
  .wb_req (wb_req),
  .wb_ack (wb_ack),
  .stall  (stall)
);

`default_nettype wire

/* sim/tb_rv_core_top.sv */
`default_nettype none

module tb_rv_core_top import rv_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] tb_reset_pc = 32'h8000_0000;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  logic        clk;
  logic        reset;
  logic [31:0] inst = 32'h0;
  logic [31:0] pc;
  logic        halt;
  wb_req_t     wb_req;
  logic [31:0] wb_dat_r = 32'h0;
  logic        wb_ack = 1'b0;

  // program and data images
  logic [31:0] rom [256];
  logic [31:0] dmem [256];
  int          rom_len;
  int          slot_count;
  logic [31:0] exp_q [$];
  logic [31:0] rom_off;

  // slave state
  wb_req_t     req_seen = '0;
  logic        busy = 1'b0;
  logic [1:0]  wait_left = 2'd0;
  logic        random_waits = 1'b0;
  logic [15:0] lfsr_state = 16'd85;

  rv_core_top #(
    .reset_pc       (tb_reset_pc),
    .reg_addr_width (5)
  ) i_dut (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .pc       (pc),
    .halt     (halt),
    .wb_req   (wb_req),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  // two bits, one step each
  function automatic logic [1:0] draw_wait();
    logic [1:0] w;
    w[0] = lfsr_step();
    w[1] = lfsr_step();
    return w;
  endfunction

  // every word differs, derived from its index
  function automatic logic [31:0] fill_word(int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a ^ 8'hA5, ~a, a + 8'h3C, a};
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
  endfunction

  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, opcode_e op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_u(int imm, int rd, opcode_e op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
  endfunction

  // branch rule per funct3
  function automatic logic branch_taken(int f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      0:       return a == b;
      1:       return a != b;
      4:       return $signed(a) < $signed(b);
      5:       return $signed(a) >= $signed(b);
      6:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  // address of the next emitted instruction
  function automatic logic [31:0] here();
    return tb_reset_pc + 32'(rom_len) * 32'd4;
  endfunction

  task automatic emit(input logic [31:0] w);
    rom[rom_len] = w;
    rom_len++;
  endtask

  // lui plus addi, hi rounded for the signed low part
  task automatic load_const(input int rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    emit(enc_u(int'(hi), rd, opc_lui));
    emit(enc_i(int'(v[11:0]), rd, 0, rd, opc_op_imm));
  endtask

  // result slots start at 0x300
  task automatic store_and_expect(input int rs, input logic [31:0] v);
    emit(enc_s(768 + 4 * slot_count, rs, 0, 2));
    exp_q.push_back(v);
    slot_count++;
  endtask

  task automatic new_program();
    for (int i = 0; i < 256; i++) begin
      rom[i] = ebreak_word;
      dmem[i] = fill_word(i);
    end
    rom_len = 0;
    slot_count = 0;
    exp_q.delete();
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "data check");
    end
  endtask

  task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: pc is %h expected %h", $time, got, exp);
      $display("Something failed");
      $fatal(1, "pc check");
    end
  endtask

  task automatic check_slots();
    for (int k = 0; k < slot_count; k++) begin
      check_word("stored result", dmem[192 + k], exp_q[k]);
    end
  endtask

  // reset for two cycles, then wait for ebreak
  task automatic run_program(input logic use_random);
    int cycles;
    random_waits = use_random;
    @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (!halt && cycles < 4000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("timeout at %0t ns: core never reached ebreak", $time);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  endtask

  task automatic test_alu(input logic use_random);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] auipc_pc;
    a = 32'hFFFF_FB2E;
    b = 32'd77;
    new_program();
    emit(enc_i(-1234, 0, 0, 1, opc_op_imm));
    emit(enc_i(77, 0, 0, 2, opc_op_imm));
    store_and_expect(1, a);
    store_and_expect(2, b);
    emit(enc_r(0, 2, 1, 0, 3));
    store_and_expect(3, a + b);
    emit(enc_r(32, 2, 1, 0, 3));
    store_and_expect(3, a - b);
    emit(enc_r(0, 2, 1, 7, 3));
    store_and_expect(3, a & b);
    emit(enc_r(0, 2, 1, 6, 3));
    store_and_expect(3, a | b);
    emit(enc_r(0, 2, 1, 4, 3));
    store_and_expect(3, a ^ b);
    emit(enc_r(0, 2, 1, 2, 3));
    store_and_expect(3, {31'b0, $signed(a) < $signed(b)});
    emit(enc_r(0, 2, 1, 3, 3));
    store_and_expect(3, {31'b0, a < b});
    // shift amount from x2, low five bits
    emit(enc_r(0, 2, 1, 1, 3));
    store_and_expect(3, a << b[4:0]);
    emit(enc_r(0, 2, 1, 5, 3));
    store_and_expect(3, a >> b[4:0]);
    emit(enc_r(32, 2, 1, 5, 3));
    store_and_expect(3, 32'($signed(a) >>> b[4:0]));
    emit(enc_i(3, 1, 1, 3, opc_op_imm));
    store_and_expect(3, a << 3);
    // srai, funct7 in imm[11:5]
    emit(enc_i(32'h405, 1, 5, 3, opc_op_imm));
    store_and_expect(3, 32'($signed(a) >>> 5));
    emit(enc_i(-7, 1, 4, 3, opc_op_imm));
    store_and_expect(3, a ^ 32'hFFFF_FFF9);
    emit(enc_i(-1, 2, 3, 3, opc_op_imm));
    store_and_expect(3, 32'd1);
    emit(enc_i(100, 1, 2, 3, opc_op_imm));
    store_and_expect(3, 32'd1);
    emit(enc_u(32'hABCDE, 3, opc_lui));
    store_and_expect(3, 32'hABCD_E000);
    // auipc adds its own address
    auipc_pc = here();
    emit(enc_u(32'h12, 3, opc_auipc));
    store_and_expect(3, auipc_pc + 32'h12000);
    emit(ebreak_word);
    run_program(use_random);
    check_slots();
  endtask

  task automatic test_loads(input logic use_random);
    logic [31:0] word;
    logic [7:0]  bv;
    logic [15:0] hv;
    new_program();
    dmem[128] = 32'h8F7F_80FF;
    dmem[129] = 32'h7E56_12F4;
    for (int w = 0; w < 2; w++) begin
      word = dmem[128 + w];
      for (int o = 0; o < 4; o++) begin
        bv = word[8 * o +: 8];
        emit(enc_i(512 + 4 * w + o, 0, 0, 1, opc_load));
        store_and_expect(1, {{24{bv[7]}}, bv});
        emit(enc_i(512 + 4 * w + o, 0, 4, 1, opc_load));
        store_and_expect(1, {24'b0, bv});
      end
      for (int o = 0; o < 4; o += 2) begin
        hv = word[8 * o +: 16];
        emit(enc_i(512 + 4 * w + o, 0, 1, 1, opc_load));
        store_and_expect(1, {{16{hv[15]}}, hv});
        emit(enc_i(512 + 4 * w + o, 0, 5, 1, opc_load));
        store_and_expect(1, {16'b0, hv});
      end
      emit(enc_i(512 + 4 * w, 0, 2, 1, opc_load));
      store_and_expect(1, word);
    end
    emit(ebreak_word);
    run_program(use_random);
    check_slots();
  endtask

  task automatic test_stores(input logic use_random);
    logic [31:0] v;
    logic [31:0] exp;
    v = 32'h5A6B_7C8D;
    new_program();
    load_const(1, v);
    // byte o into word 160 + o
    for (int o = 0; o < 4; o++) begin
      emit(enc_s(640 + 5 * o, 1, 0, 0));
    end
    emit(enc_s(656, 1, 0, 1));
    emit(enc_s(662, 1, 0, 1));
    emit(enc_s(664, 1, 0, 2));
    emit(ebreak_word);
    run_program(use_random);
    for (int o = 0; o < 4; o++) begin
      exp = fill_word(160 + o);
      exp[8 * o +: 8] = v[7:0];
      check_word("sb lane", dmem[160 + o], exp);
    end
    exp = fill_word(164);
    exp[15:0] = v[15:0];
    check_word("sh low half", dmem[164], exp);
    exp = fill_word(165);
    exp[31:16] = v[15:0];
    check_word("sh high half", dmem[165], exp);
    check_word("sw word", dmem[166], v);
    check_word("untouched word", dmem[167], fill_word(167));
  endtask

  task automatic test_control(input logic use_random, output logic [31:0] halt_pc);
    int          conds [6];
    logic [31:0] vals [3];
    logic [31:0] p;
    conds = '{0, 1, 4, 5, 6, 7};
    vals = '{32'd0, 32'd5, 32'hFFFF_FFFD};
    new_program();
    emit(enc_i(5, 0, 0, 1, opc_op_imm));
    emit(enc_i(-3, 0, 0, 2, opc_op_imm));
    // marker 1 when taken, 2 when not
    for (int c = 0; c < 6; c++) begin
      for (int pr = 0; pr < 3; pr++) begin
        int ra;
        int rb;
        ra = (pr == 1) ? 2 : 1;
        rb = (pr == 0) ? 2 : 1;
        emit(enc_i(1, 0, 0, 3, opc_op_imm));
        emit(enc_b(8, rb, ra, conds[c]));
        emit(enc_i(2, 0, 0, 3, opc_op_imm));
        store_and_expect(3, branch_taken(conds[c], vals[ra], vals[rb]) ? 32'd1 : 32'd2);
      end
    end
    p = here();
    emit(enc_j(8, 5));
    emit(enc_i(9, 0, 0, 6, opc_op_imm));
    store_and_expect(5, p + 32'd4);
    store_and_expect(6, 32'd0);
    // target rs1 + 13, bit 0 cleared
    p = here();
    emit(enc_u(0, 7, opc_auipc));
    emit(enc_i(13, 7, 0, 8, opc_jalr));
    emit(enc_i(1, 0, 0, 9, opc_op_imm));
    store_and_expect(8, p + 32'd8);
    store_and_expect(9, 32'd0);
    halt_pc = here();
    emit(ebreak_word);
    run_program(use_random);
    check_slots();
    check_pc(pc, halt_pc);
  endtask

  task automatic test_backpressure_halt();
    logic [31:0] halt_pc;
    logic [31:0] slot_before;
    test_alu(1'b1);
    test_loads(1'b1);
    test_stores(1'b1);
    test_control(1'b1, halt_pc);
    // a store now sits at the halted pc and must stay off the bus
    slot_before = dmem[192];
    rom[(halt_pc - tb_reset_pc) >> 2] = enc_s(768, 1, 0, 2);
    repeat (20) begin
      @(posedge clk);
      check_pc(pc, halt_pc);
      if (wb_req.cyc || wb_req.stb) begin
        $display("bus cycle started at %0t ns although the core is halted", $time);
        $display("Something failed");
        $fatal(1, "bus after halt");
      end
    end
    check_word("memory after halt", dmem[192], slot_before);
  endtask

  assign rom_off = pc - tb_reset_pc;

  // request as seen at the rising edge
  always @(posedge clk) begin
    req_seen = wb_req;
  end

  // rom fetch and wishbone slave
  always @(negedge clk) begin
    inst = rom[rom_off[9:2]];
    if (reset || wb_ack) begin
      wb_ack = 1'b0;
      busy = 1'b0;
    end else begin
      if (!busy && req_seen.cyc && req_seen.stb) begin
        busy = 1'b1;
        wait_left = random_waits ? draw_wait() : 2'd0;
      end
      if (busy) begin
        if (wait_left == 2'd0) begin
          // write selected lanes, return the whole word
          for (int b = 0; b < 4; b++) begin
            if (req_seen.we && req_seen.sel[b]) begin
              dmem[req_seen.adr[9:2]][8 * b +: 8] = req_seen.dat[8 * b +: 8];
            end
          end
          wb_dat_r = dmem[req_seen.adr[9:2]];
          wb_ack = 1'b1;
        end else begin
          wait_left = wait_left - 2'd1;
        end
      end
    end
  end

  initial begin
    logic [31:0] halt_pc;
    reset = 1'b1;
    test_alu(1'b0);
    test_loads(1'b0);
    test_stores(1'b0);
    test_control(1'b0, halt_pc);
    test_backpressure_halt();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* src/rv_core_top.sv */
`default_nettype none

module rv_core_top import rv_pkg::*; #(
  parameter logic [31:0] reset_pc       = 32'h8000_0000,
  parameter int unsigned reg_addr_width = 5
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] inst,
  output logic [31:0] pc,
  output logic        halt,
  output wb_req_t     wb_req,
  input  logic [31:0] wb_dat_r,
  input  logic        wb_ack
);

  ctrl_t                     ctrl;
  logic [31:0]               imm;
  logic [reg_addr_width-1:0] rs1;
  logic [reg_addr_width-1:0] rs2;
  logic [reg_addr_width-1:0] rd;
  logic [31:0]               rs1_data;
  logic [31:0]               rs2_data;
  logic [31:0]               alu_result;
  logic [31:0]               next_pc;
  logic [31:0]               link_pc;
  logic                      rd_we;
  logic [reg_addr_width-1:0] rd_addr;
  logic [31:0]               rd_data;
  logic                      stall;
  logic                      retire;
  logic                      bus_off;

  // instruction leaves at this edge
  assign retire = !halt && !stall;

  // bus idle and no writeback in reset or once halted
  assign bus_off = halt || reset;

  // pc and halt flag
  // ebreak keeps pc on its own address
  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (retire) begin
      if (ctrl.ebreak) begin
        halt <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

  rv_decode #(
    .reg_addr_width(reg_addr_width)
  ) i_decode (
    .inst (inst_u'(inst)),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  rv_regfile #(
    .reg_addr_width(reg_addr_width)
  ) i_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd_we    (rd_we),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute i_execute (
    .ctrl       (ctrl),
    .imm        (imm),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .next_pc    (next_pc),
    .link_pc    (link_pc)
  );

  // bus master and writeback
  rv_result #(
    .reg_addr_width(reg_addr_width)
  ) i_result (
    .ctrl       (ctrl),
    .rd         (rd),
    .halt       (bus_off),
    .alu_result (alu_result),
    .link_pc    (link_pc),
    .rs2_data   (rs2_data),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_req     (wb_req),
    .rd_we      (rd_we),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .stall      (stall)
  );

endmodule

`default_nettype wire

/* src/rv_decode.sv */
`default_nettype none

module rv_decode import rv_pkg::*; #(
  parameter int unsigned reg_addr_width = 5
) (
  input  inst_u                     inst,
  output ctrl_t                     ctrl,
  output logic [31:0]               imm,
  output logic [reg_addr_width-1:0] rs1,
  output logic [reg_addr_width-1:0] rs2,
  output logic [reg_addr_width-1:0] rd
);

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic        f7_zero;
  logic        f7_alt;
  logic        op_ok;
  logic        op_imm_ok;
  logic        imm_alt;
  logic        ld_ok;
  logic        st_ok;
  logic        br_ok;
  logic        is_ebreak;

  // funct3 to alu function, alt picks sub or sra
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  // register fields sit at the same bits in every format
  // upper bits dropped for rv32e
  assign rs1 = inst.r.rs1[reg_addr_width-1:0];
  assign rs2 = inst.r.rs2[reg_addr_width-1:0];
  assign rd  = inst.r.rd[reg_addr_width-1:0];

  // sign extended immediates per format
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                  inst.b.imm10_5, inst.b.imm4_1, 1'b0};
  assign imm_u = {inst.u.imm, 12'h000};
  assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                  inst.j.imm11, inst.j.imm10_1, 1'b0};

  // funct7 legality
  assign f7_zero = inst.r.funct7 == 7'b000_0000;
  assign f7_alt  = inst.r.funct7 == 7'b010_0000;
  // alt form only for sub and sra
  assign op_ok   = f7_zero || (f7_alt && (inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101));
  // shift immediates carry funct7 in imm[11:5]
  assign op_imm_ok = (inst.i.funct3 != 3'b001 && inst.i.funct3 != 3'b101) || f7_zero ||
                     (f7_alt && inst.i.funct3 == 3'b101);
  // srai only, addi with imm[10] set must stay an add
  assign imm_alt = f7_alt && inst.i.funct3 == 3'b101;

  // lb lh lw lbu lhu
  assign ld_ok = inst.i.funct3[1:0] != 2'b11 && inst.i.funct3 != 3'b110;
  // sb sh sw
  assign st_ok = !inst.s.funct3[2] && inst.s.funct3[1:0] != 2'b11;
  // 010 and 011 reserved
  assign br_ok = inst.b.funct3[2:1] != 2'b01;
  assign is_ebreak = inst.i.imm == 12'h001 && inst.i.rs1 == 5'd0 &&
                     inst.i.funct3 == 3'b000 && inst.i.rd == 5'd0;

  always_comb begin
    // default is a control word with no effect
    ctrl          = '0;
    ctrl.alu_op   = alu_add;
    ctrl.br_cond  = br_eq;
    ctrl.mem_size = size_word;
    ctrl.wb_sel   = wb_none;
    imm           = '0;
    case (inst.r.opcode)
      opc_op: begin
        if (op_ok) begin
          ctrl.alu_op = alu_from_f3(inst.r.funct3, inst.r.funct7[5]);
          ctrl.wb_sel = wb_alu;
        end
      end
      opc_op_imm: begin
        imm = imm_i;
        if (op_imm_ok) begin
          ctrl.alu_op  = alu_from_f3(inst.i.funct3, imm_alt);
          ctrl.op2_imm = 1'b1;
          ctrl.wb_sel  = wb_alu;
        end
      end
      opc_load: begin
        imm = imm_i;
        if (ld_ok) begin
          ctrl.load          = 1'b1;
          ctrl.op2_imm       = 1'b1;
          ctrl.mem_size      = mem_size_e'(inst.i.funct3[1:0]);
          ctrl.load_unsigned = inst.i.funct3[2];
          ctrl.wb_sel        = wb_mem;
        end
      end
      opc_store: begin
        imm = imm_s;
        if (st_ok) begin
          ctrl.store    = 1'b1;
          ctrl.op2_imm  = 1'b1;
          ctrl.mem_size = mem_size_e'(inst.s.funct3[1:0]);
        end
      end
      opc_branch: begin
        imm = imm_b;
        if (br_ok) begin
          ctrl.branch  = 1'b1;
          ctrl.br_cond = br_cond_e'(inst.b.funct3);
        end
      end
      opc_lui: begin
        imm          = imm_u;
        ctrl.alu_op  = alu_pass_b;
        ctrl.op2_imm = 1'b1;
        ctrl.wb_sel  = wb_alu;
      end
      opc_auipc: begin
        imm          = imm_u;
        ctrl.op1_pc  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.wb_sel  = wb_alu;
      end
      opc_jal: begin
        imm         = imm_j;
        ctrl.jal    = 1'b1;
        ctrl.wb_sel = wb_pc4;
      end
      opc_jalr: begin
        imm = imm_i;
        if (inst.i.funct3 == 3'b000) begin
          ctrl.jalr    = 1'b1;
          ctrl.op2_imm = 1'b1;
          ctrl.wb_sel  = wb_pc4;
        end
      end
      opc_system: begin
        // ecall and csr ops retire as no-ops
        ctrl.ebreak = is_ebreak;
      end
      default: begin
        // unknown opcode, keep defaults
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  ctrl_t       ctrl,
  input  logic [31:0] imm,
  input  logic [31:0] pc,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  output logic [31:0] alu_result,
  output logic [31:0] next_pc,
  output logic [31:0] link_pc
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shamt;
  logic [31:0] jump_target;
  logic        rs_eq;
  logic        rs_lt;
  logic        rs_ltu;
  logic        taken;

  // operand muxes
  assign op_a  = ctrl.op1_pc ? pc : rs1_data;
  assign op_b  = ctrl.op2_imm ? imm : rs2_data;
  // only the low five bits shift on rv32
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_or:     alu_result = op_a | op_b;
      alu_xor:    alu_result = op_a ^ op_b;
      alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {31'b0, op_a < op_b};
      alu_sll:    alu_result = op_a << shamt;
      alu_srl:    alu_result = op_a >> shamt;
      alu_sra:    alu_result = $unsigned($signed(op_a) >>> shamt);
      alu_pass_b: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // comparator works on the register values, not the alu operands
  assign rs_eq  = rs1_data == rs2_data;
  assign rs_lt  = $signed(rs1_data) < $signed(rs2_data);
  assign rs_ltu = rs1_data < rs2_data;

  always_comb begin
    case (ctrl.br_cond)
      br_eq:   taken = rs_eq;
      br_ne:   taken = !rs_eq;
      br_lt:   taken = rs_lt;
      br_ge:   taken = !rs_lt;
      br_ltu:  taken = rs_ltu;
      br_geu:  taken = !rs_ltu;
      default: taken = 1'b0;
    endcase
  end

  // shared by jal and branches
  assign jump_target = pc + imm;
  assign link_pc     = pc + 32'd4;

  always_comb begin
    if (ctrl.jalr) begin
      // rs1 + imm from the alu, bit 0 cleared
      next_pc = {alu_result[31:1], 1'b0};
    end else if (ctrl.jal || (ctrl.branch && taken)) begin
      next_pc = jump_target;
    end else begin
      next_pc = link_pc;
    end
  end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    opc_load   = 7'b000_0011,
    opc_op_imm = 7'b001_0011,
    opc_auipc  = 7'b001_0111,
    opc_store  = 7'b010_0011,
    opc_op     = 7'b011_0011,
    opc_lui    = 7'b011_0111,
    opc_branch = 7'b110_0011,
    opc_jalr   = 7'b110_0111,
    opc_jal    = 7'b110_1111,
    opc_system = 7'b111_0011
  } opcode_e;

  // alu functions, pass_b feeds lui
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_e;

  // branch funct3 codes, 010 and 011 are reserved
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_cond_e;

  // same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  // where rd gets its value from
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc4,
    wb_none
  } wb_sel_e;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // one instruction word, six ways to read it
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } inst_u;

  // decoded control word
  typedef struct packed {
    alu_op_e   alu_op;
    logic      op1_pc;
    logic      op2_imm;
    logic      branch;
    br_cond_e  br_cond;
    logic      jal;
    logic      jalr;
    logic      load;
    logic      store;
    mem_size_e mem_size;
    logic      load_unsigned;
    wb_sel_e   wb_sel;
    logic      ebreak;
  } ctrl_t;

  // wishbone classic master request
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
`default_nettype none

module rv_regfile #(
  parameter int unsigned reg_addr_width = 5
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] rs1,
  input  logic [reg_addr_width-1:0] rs2,
  input  logic                      rd_we,
  input  logic [reg_addr_width-1:0] rd_addr,
  input  logic [31:0]               rd_data,
  output logic [31:0]               rs1_data,
  output logic [31:0]               rs2_data
);

  // 32 entries for rv32i, 16 for rv32e
  localparam int unsigned num_regs = 2 ** reg_addr_width;

  logic [31:0] regs [num_regs];

  // single write port
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 reads zero whatever the array holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* src/rv_result.sv */
`default_nettype none

module rv_result import rv_pkg::*; #(
  parameter int unsigned reg_addr_width = 5
) (
  input  ctrl_t                     ctrl,
  input  logic [reg_addr_width-1:0] rd,
  input  logic                      halt,
  input  logic [31:0]               alu_result,
  input  logic [31:0]               link_pc,
  input  logic [31:0]               rs2_data,
  input  logic [31:0]               wb_dat_r,
  input  logic                      wb_ack,
  output wb_req_t                   wb_req,
  output logic                      rd_we,
  output logic [reg_addr_width-1:0] rd_addr,
  output logic [31:0]               rd_data,
  output logic                      stall
);

  logic        mem_op;
  logic [1:0]  byte_off;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic [31:0] ld_data;

  // no bus cycles once halted
  assign mem_op   = (ctrl.load || ctrl.store) && !halt;
  assign byte_off = alu_result[1:0];

  // cyc and stb follow the decoded instruction
  // word aligned address, lanes picked by sel
  always_comb begin
    wb_req.cyc = mem_op;
    wb_req.stb = mem_op;
    wb_req.we  = mem_op && ctrl.store;
    wb_req.adr = {alu_result[31:2], 2'b00};
    case (ctrl.mem_size)
      size_byte: begin
        // byte copied into every lane
        wb_req.dat = {4{rs2_data[7:0]}};
        wb_req.sel = 4'b0001 << byte_off;
      end
      size_half: begin
        wb_req.dat = {2{rs2_data[15:0]}};
        wb_req.sel = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wb_req.dat = rs2_data;
        wb_req.sel = 4'b1111;
      end
    endcase
  end

  // pick the addressed lane out of the read word
  assign ld_byte = wb_dat_r[{byte_off, 3'b000} +: 8];
  assign ld_half = byte_off[1] ? wb_dat_r[31:16] : wb_dat_r[15:0];

  always_comb begin
    case (ctrl.mem_size)
      size_byte: begin
        if (ctrl.load_unsigned) begin
          ld_data = {24'b0, ld_byte};
        end else begin
          ld_data = {{24{ld_byte[7]}}, ld_byte};
        end
      end
      size_half: begin
        if (ctrl.load_unsigned) begin
          ld_data = {16'b0, ld_half};
        end else begin
          ld_data = {{16{ld_half[15]}}, ld_half};
        end
      end
      default: ld_data = wb_dat_r;
    endcase
  end

  // wait for the slave
  assign stall = mem_op && !wb_ack;

  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  rd_data = ld_data;
      wb_pc4:  rd_data = link_pc;
      default: rd_data = alu_result;
    endcase
  end

  // write only on the retiring edge
  assign rd_we   = ctrl.wb_sel != wb_none && !halt && !stall;
  assign rd_addr = rd;

endmodule

`default_nettype wire
